// ==== Makefile ====
# Verilator build and run of the SRAM FIFO testbench

TOP := sram_fifo_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/fifo_controller.sv ====
// SRAM FIFO controller with read/write pointers, word count
// and registered empty, almost-full and full flags
`timescale 1ns/100ps
`default_nettype none

`include "sram_fifo_macros.svh"

module fifo_controller #(
  parameter int THRESHOLD = `SRAM_FIFO_THRESHOLD
)(
  input  var logic                            i_clk,
  input  var logic                            i_rst_n,
  input  var logic                            i_clear,
  input  var logic                            i_push,
  input  var logic                            i_pop,
  output var logic                            o_empty,
  output var logic                            o_almost_full,
  output var logic                            o_full,
  output var logic [`SRAM_FIFO_PTR_WIDTH-1:0] o_write_pointer,
  output var logic [`SRAM_FIFO_PTR_WIDTH-1:0] o_read_pointer
);
  localparam int DEPTH       = `SRAM_FIFO_DEPTH;
  localparam int PTR_WIDTH   = `SRAM_FIFO_PTR_WIDTH;
  localparam int COUNT_WIDTH = PTR_WIDTH + 1;

  localparam logic [PTR_WIDTH-1:0]   LAST_POINTER      = PTR_WIDTH'(DEPTH - 1);
  localparam logic [COUNT_WIDTH-1:0] FULL_COUNT        = COUNT_WIDTH'(DEPTH);
  localparam logic [COUNT_WIDTH-1:0] ALMOST_FULL_COUNT = COUNT_WIDTH'(THRESHOLD);

  logic                   push_en;
  logic                   pop_en;
  logic [PTR_WIDTH-1:0]   write_pointer;
  logic [PTR_WIDTH-1:0]   read_pointer;
  logic [COUNT_WIDTH-1:0] word_count;
  logic [COUNT_WIDTH-1:0] word_count_next;
  logic                   empty;
  logic                   almost_full;
  logic                   full;

  // pointers wrap at the last SRAM word, depth need not be a power of two
  function automatic logic [PTR_WIDTH-1:0] advance(input logic [PTR_WIDTH-1:0] pointer);
    logic [PTR_WIDTH-1:0] next_pointer;
    if (pointer == LAST_POINTER) begin
      next_pointer = '0;
    end else begin
      next_pointer = pointer + 1'b1;
    end
    return next_pointer;
  endfunction

  always_comb begin
    // guard against overflow and underflow even if the caller does not
    push_en = i_push && !full;
    pop_en  = i_pop && !empty;
    case ({push_en, pop_en})
      2'b10:   word_count_next = word_count + 1'b1;
      2'b01:   word_count_next = word_count - 1'b1;
      default: word_count_next = word_count;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      write_pointer <= '0;
      read_pointer  <= '0;
      word_count    <= '0;
    end else if (i_clear) begin
      write_pointer <= '0;
      read_pointer  <= '0;
      word_count    <= '0;
    end else begin
      if (push_en) begin
        write_pointer <= advance(write_pointer);
      end
      if (pop_en) begin
        read_pointer <= advance(read_pointer);
      end
      word_count <= word_count_next;
    end
  end

  // flags come from the next count so they line up with word_count
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      empty       <= 1'b1;
      almost_full <= 1'b0;
      full        <= 1'b0;
    end else if (i_clear) begin
      empty       <= 1'b1;
      almost_full <= 1'b0;
      full        <= 1'b0;
    end else begin
      empty       <= word_count_next == '0;
      almost_full <= word_count_next >= ALMOST_FULL_COUNT;
      full        <= word_count_next == FULL_COUNT;
    end
  end

  always_comb begin
    o_empty         = empty;
    o_almost_full   = almost_full;
    o_full          = full;
    o_write_pointer = write_pointer;
    o_read_pointer  = read_pointer;
  end

endmodule

`default_nettype wire

// ==== design/sram_array.sv ====
// dual-port SRAM macro model with a READ_LATENCY-stage read pipeline
`timescale 1ns/100ps
`default_nettype none

`include "sram_fifo_macros.svh"

module sram_array #(
  parameter int READ_LATENCY = `SRAM_FIFO_READ_LATENCY
)(
  input  var logic                          i_clk,
  input  var logic                          i_rst_n,
  input  var logic                          i_clear,
  input  var sram_fifo_pkg::sram_write_t    i_write,
  input  var sram_fifo_pkg::sram_read_req_t i_read,
  output var logic                          o_read_valid,
  output var sram_fifo_pkg::fifo_data_t     o_read_data
);
  import sram_fifo_pkg::*;

  localparam int DEPTH = `SRAM_FIFO_DEPTH;

  fifo_data_t              memory [DEPTH];
  logic [READ_LATENCY-1:0] valid_pipe;
  fifo_data_t              data_pipe [READ_LATENCY];

  always_ff @(posedge i_clk) begin
    if (i_write.valid) begin
      memory[i_write.pointer] <= i_write.data;
    end
  end

  // stage 0 is the array access itself, later stages model the output registers
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_pipe <= '0;
    end else if (i_clear) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= i_read.valid;
      for (int i = 1; i < READ_LATENCY; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_read.valid) begin
      data_pipe[0] <= memory[i_read.pointer];
    end
    for (int i = 1; i < READ_LATENCY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  always_comb begin
    o_read_valid = valid_pipe[READ_LATENCY-1];
    o_read_data  = data_pipe[READ_LATENCY-1];
  end

endmodule

`default_nettype wire

// ==== design/sram_fifo.sv ====
// SRAM FIFO top level joining controller, SRAM array and read buffer
// and forming the external status flags
`timescale 1ns/100ps
`default_nettype none

`include "sram_fifo_macros.svh"

module sram_fifo #(
  parameter int THRESHOLD    = `SRAM_FIFO_THRESHOLD,
  parameter int READ_LATENCY = `SRAM_FIFO_READ_LATENCY
)(
  input  var logic                        i_clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_clear,
  input  var logic                        i_push,
  input  var sram_fifo_pkg::fifo_data_t   i_data,
  input  var logic                        i_pop,
  output var sram_fifo_pkg::fifo_status_t o_status,
  output var sram_fifo_pkg::fifo_data_t   o_data
);
  import sram_fifo_pkg::*;

  logic                            empty;
  logic                            almost_full;
  logic                            full;
  logic                            write_ack;
  logic                            read_ack;
  logic [`SRAM_FIFO_PTR_WIDTH-1:0] write_pointer;
  logic [`SRAM_FIFO_PTR_WIDTH-1:0] read_pointer;
  sram_write_t                     sram_write;
  sram_read_req_t                  sram_read;
  logic                            read_valid;
  fifo_data_t                      read_data;
  logic                            buffer_empty;
  logic                            buffer_full;
  logic                            read_busy;

  // pushes while full are dropped
  always_comb begin
    write_ack = i_push && !full;
  end

  fifo_controller #(
    .THRESHOLD  (THRESHOLD)
  ) u_controller (
    .i_clk            (i_clk         ),
    .i_rst_n          (i_rst_n       ),
    .i_clear          (i_clear       ),
    .i_push           (write_ack     ),
    .i_pop            (read_ack      ),
    .o_empty          (empty         ),
    .o_almost_full    (almost_full   ),
    .o_full           (full          ),
    .o_write_pointer  (write_pointer ),
    .o_read_pointer   (read_pointer  )
  );

  always_comb begin
    sram_write.valid   = write_ack;
    sram_write.pointer = write_pointer;
    sram_write.data    = i_data;
    // the buffer only acks when it has room for the returning word
    sram_read.valid    = read_ack;
    sram_read.pointer  = read_pointer;
  end

  sram_array #(
    .READ_LATENCY (READ_LATENCY)
  ) u_sram (
    .i_clk        (i_clk      ),
    .i_rst_n      (i_rst_n    ),
    .i_clear      (i_clear    ),
    .i_write      (sram_write ),
    .i_read       (sram_read  ),
    .o_read_valid (read_valid ),
    .o_read_data  (read_data  )
  );

  sram_read_buffer #(
    .READ_LATENCY (READ_LATENCY)
  ) u_read_buffer (
    .i_clk          (i_clk        ),
    .i_rst_n        (i_rst_n      ),
    .i_clear        (i_clear      ),
    .i_source_empty (empty        ),
    .i_read_valid   (read_valid   ),
    .i_read_data    (read_data    ),
    .i_pop          (i_pop        ),
    .o_read_ack     (read_ack     ),
    .o_empty        (buffer_empty ),
    .o_full         (buffer_full  ),
    .o_busy         (read_busy    ),
    .o_data         (o_data       )
  );

  // almost_full and full count SRAM words only
  always_comb begin
    o_status.empty            = buffer_empty;
    o_status.completely_empty = buffer_empty && empty && !read_busy;
    o_status.almost_full      = almost_full;
    o_status.full             = full;
    o_status.completely_full  = full && buffer_full;
  end

endmodule

`default_nettype wire

// ==== design/sram_fifo_macros.svh ====
// width, depth and pointer size of the SRAM FIFO
// default almost-full threshold and SRAM read latency
`ifndef SRAM_FIFO_MACROS_SVH
`define SRAM_FIFO_MACROS_SVH

// data word width in bits
`define SRAM_FIFO_WIDTH 16

// number of words in the SRAM macro
`define SRAM_FIFO_DEPTH 16

// SRAM address width
`define SRAM_FIFO_PTR_WIDTH $clog2(`SRAM_FIFO_DEPTH)

// almost-full level, counted in SRAM words
`define SRAM_FIFO_THRESHOLD 12

// cycles from read request to read data
`define SRAM_FIFO_READ_LATENCY 2

`endif

// ==== design/sram_fifo_pkg.sv ====
// data word, SRAM port request structs and FIFO status flags
`default_nettype none

`include "sram_fifo_macros.svh"

package sram_fifo_pkg;

  typedef logic [`SRAM_FIFO_WIDTH-1:0] fifo_data_t;

  // write port of the SRAM macro
  typedef struct packed {
    logic                            valid;
    logic [`SRAM_FIFO_PTR_WIDTH-1:0] pointer;
    fifo_data_t                      data;
  } sram_write_t;

  // read port of the SRAM macro
  typedef struct packed {
    logic                            valid;
    logic [`SRAM_FIFO_PTR_WIDTH-1:0] pointer;
  } sram_read_req_t;

  // empty/full refer to the show-ahead side and the SRAM part,
  // the completely_* flags to the FIFO as a whole
  typedef struct packed {
    logic empty;
    logic completely_empty;
    logic almost_full;
    logic full;
    logic completely_full;
  } fifo_status_t;

endpackage

`default_nettype wire

// ==== design/sram_read_buffer.sv ====
// show-ahead output buffer behind the SRAM with credits for reads in flight
`timescale 1ns/100ps
`default_nettype none

module sram_read_buffer #(
  parameter int READ_LATENCY = 1
)(
  input  var logic                      i_clk,
  input  var logic                      i_rst_n,
  input  var logic                      i_clear,
  input  var logic                      i_source_empty,
  input  var logic                      i_read_valid,
  input  var sram_fifo_pkg::fifo_data_t i_read_data,
  input  var logic                      i_pop,
  output var logic                      o_read_ack,
  output var logic                      o_empty,
  output var logic                      o_full,
  output var logic                      o_busy,
  output var sram_fifo_pkg::fifo_data_t o_data
);
  import sram_fifo_pkg::*;

  // one entry per pipeline stage plus one so reads can stream back to back
  localparam int ENTRIES     = READ_LATENCY + 1;
  localparam int INDEX_WIDTH = $clog2(ENTRIES);
  localparam int COUNT_WIDTH = $clog2(ENTRIES + 1);

  localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(ENTRIES - 1);
  localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(ENTRIES);

  fifo_data_t             entry [ENTRIES];
  logic [INDEX_WIDTH-1:0] write_index;
  logic [INDEX_WIDTH-1:0] read_index;
  logic [COUNT_WIDTH-1:0] entry_count;
  logic [COUNT_WIDTH-1:0] inflight_count;
  logic [COUNT_WIDTH:0]   occupancy;
  logic                   credit;
  logic                   read_ack;
  logic                   pop_en;
  logic                   empty;

  function automatic logic [INDEX_WIDTH-1:0] advance(input logic [INDEX_WIDTH-1:0] index);
    logic [INDEX_WIDTH-1:0] next_index;
    if (index == LAST_INDEX) begin
      next_index = '0;
    end else begin
      next_index = index + 1'b1;
    end
    return next_index;
  endfunction

  always_comb begin
    // stored words plus words still coming out of the SRAM
    occupancy = {1'b0, entry_count} + {1'b0, inflight_count};
    credit    = occupancy < (COUNT_WIDTH + 1)'(ENTRIES);
    read_ack  = !i_source_empty && credit;
    empty     = entry_count == '0;
    pop_en    = i_pop && !empty;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      write_index    <= '0;
      read_index     <= '0;
      entry_count    <= '0;
      inflight_count <= '0;
    end else if (i_clear) begin
      write_index    <= '0;
      read_index     <= '0;
      entry_count    <= '0;
      inflight_count <= '0;
    end else begin
      if (i_read_valid) begin
        write_index <= advance(write_index);
      end
      if (pop_en) begin
        read_index <= advance(read_index);
      end
      entry_count    <= entry_count + COUNT_WIDTH'(i_read_valid) - COUNT_WIDTH'(pop_en);
      inflight_count <= inflight_count + COUNT_WIDTH'(read_ack) - COUNT_WIDTH'(i_read_valid);
    end
  end

  // the credit check guarantees a free entry for every returning word
  always_ff @(posedge i_clk) begin
    if (i_read_valid) begin
      entry[write_index] <= i_read_data;
    end
  end

  always_comb begin
    o_read_ack = read_ack;
    o_empty    = empty;
    o_full     = entry_count == FULL_COUNT;
    o_busy     = inflight_count != '0;
    o_data     = entry[read_index];
  end

endmodule

`default_nettype wire

// ==== tb/sram_fifo_sva.sv ====
// concurrent assertions on the SRAM FIFO status flags
// and on the controller pointers, attached to sram_fifo by bind
`timescale 1ns/100ps
`default_nettype none

`include "sram_fifo_macros.svh"

module sram_fifo_sva (
  input var logic                            i_clk,
  input var logic                            i_rst_n,
  input var logic                            i_clear,
  input var sram_fifo_pkg::fifo_status_t     i_status,
  input var logic                            i_write_ack,
  input var logic                            i_read_ack,
  input var logic [`SRAM_FIFO_PTR_WIDTH-1:0] i_write_pointer,
  input var logic [`SRAM_FIFO_PTR_WIDTH-1:0] i_read_pointer
);

  completely_full_implies_full: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_status.completely_full |-> i_status.full
  ) else $error("completely_full is set while full is low");

  completely_empty_implies_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_status.completely_empty |-> i_status.empty
  ) else $error("completely_empty is set while empty is low");

  full_and_empty_exclusive: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !(i_status.full && i_status.empty)
  ) else $error("full and empty are set in the same cycle");

  // pointers only move on an accepted push or pop, or return to zero on clear
  write_pointer_holds: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (!i_write_ack && !i_clear) |=> $stable(i_write_pointer)
  ) else $error("write pointer moved without a push");

  read_pointer_holds: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (!i_read_ack && !i_clear) |=> $stable(i_read_pointer)
  ) else $error("read pointer moved without a pop");

endmodule

`default_nettype wire

// ==== tb/sram_fifo_tb.sv ====
// testbench for the SRAM FIFO with a reference queue model,
// directed and random traffic, a compare process and a watchdog
`timescale 1ns/100ps
`default_nettype none

`include "sram_fifo_macros.svh"

module sram_fifo_tb;
  import sram_fifo_pkg::*;

  localparam int TOTAL_WORDS     = `SRAM_FIFO_DEPTH + `SRAM_FIFO_READ_LATENCY + 1;
  localparam int THRESHOLD_WORDS = `SRAM_FIFO_THRESHOLD + `SRAM_FIFO_READ_LATENCY + 1;
  localparam int SETTLE_CYCLES   = `SRAM_FIFO_READ_LATENCY + 4;
  localparam int FLAG_LIMIT      = 4 * TOTAL_WORDS + 20;
  localparam int RANDOM_CYCLES   = 600;
  localparam int WATCHDOG_CYCLES = 3000;

  logic         i_clk;
  logic         i_rst_n;
  logic         i_clear;
  logic         i_push;
  fifo_data_t   i_data;
  logic         i_pop;
  fifo_status_t o_status;
  fifo_data_t   o_data;

  fifo_data_t   model_q[$];
  int           error_count;
  int           check_count;
  int           popped;

  sram_fifo #(
    .THRESHOLD    (`SRAM_FIFO_THRESHOLD),
    .READ_LATENCY (`SRAM_FIFO_READ_LATENCY)
  ) sram_fifo_inst (
    .i_clk    (i_clk   ),
    .i_rst_n  (i_rst_n ),
    .i_clear  (i_clear ),
    .i_push   (i_push  ),
    .i_data   (i_data  ),
    .i_pop    (i_pop   ),
    .o_status (o_status),
    .o_data   (o_data  )
  );

  bind sram_fifo sram_fifo_sva sram_fifo_sva_inst (
    .i_clk           (i_clk        ),
    .i_rst_n         (i_rst_n      ),
    .i_clear         (i_clear      ),
    .i_status        (o_status     ),
    .i_write_ack     (write_ack    ),
    .i_read_ack      (read_ack     ),
    .i_write_pointer (write_pointer),
    .i_read_pointer  (read_pointer )
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // oldest word still held by the FIFO
  function automatic fifo_data_t expected_head();
    return model_q[0];
  endfunction

  function automatic logic status_flag(input string name);
    logic value;
    case (name)
      "empty":            value = o_status.empty;
      "completely_empty": value = o_status.completely_empty;
      "almost_full":      value = o_status.almost_full;
      "full":             value = o_status.full;
      "completely_full":  value = o_status.completely_full;
      default:            value = 1'bx;
    endcase
    return value;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  task automatic wait_for_flag(input string name, input logic value, input int limit);
    int cycles;
    cycles = 0;
    while (status_flag(name) !== value && cycles < limit) begin
      @(negedge i_clk);
      cycles++;
    end
    if (status_flag(name) !== value) begin
      $display("Error at %0t: flag %s did not become %b within %0d cycles",
               $time, name, value, limit);
      error_count++;
    end
  endtask

  task automatic push_words(input int count, input fifo_data_t base);
    for (int i = 0; i < count; i++) begin
      i_push = 1'b1;
      i_data = base + fifo_data_t'(i);
      @(negedge i_clk);
    end
    i_push = 1'b0;
  endtask

  task automatic pulse_clear();
    i_clear = 1'b1;
    @(negedge i_clk);
    i_clear = 1'b0;
  endtask

  // pops until the whole FIFO is empty and counts the accepted pops
  task automatic drain(output int count);
    int cycles;
    count  = 0;
    cycles = 0;
    while (!o_status.completely_empty && cycles < FLAG_LIMIT) begin
      i_pop = 1'b1;
      if (!o_status.empty) begin
        count++;
      end
      cycles++;
      @(negedge i_clk);
    end
    i_pop = 1'b0;
    if (!o_status.completely_empty) begin
      $display("Error at %0t: FIFO did not drain within %0d cycles", $time, FLAG_LIMIT);
      error_count++;
    end
  endtask

  // model follows the accepted pushes and pops and checks each pop
  always @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      model_q.delete();
    end else begin
      if (i_pop && !o_status.empty) begin
        if (model_q.size() == 0) begin
          $display("Error at %0t: DUT gave a word that was never pushed", $time);
          error_count++;
        end else begin
          check_value("o_data", 32'(o_data), 32'(expected_head()));
          void'(model_q.pop_front());
        end
      end
      if (i_push && !o_status.full) begin
        model_q.push_back(i_data);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Error: watchdog expired after %0d cycles, tests did not finish",
             WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    i_rst_n     = 1'b0;
    i_clear     = 1'b0;
    i_push      = 1'b0;
    i_pop       = 1'b0;
    i_data      = '0;
    error_count = 0;
    check_count = 0;
    void'($urandom(32'h292c));
    repeat (8) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);

    // flags after reset
    check_value("empty", 32'(o_status.empty), 32'd1);
    check_value("completely_empty", 32'(o_status.completely_empty), 32'd1);
    check_value("almost_full", 32'(o_status.almost_full), 32'd0);
    check_value("full", 32'(o_status.full), 32'd0);
    check_value("completely_full", 32'(o_status.completely_full), 32'd0);

    // random traffic that fills in the first half and drains in the second
    for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
      if (cycle < RANDOM_CYCLES / 2) begin
        i_push = ($urandom % 4) != 0;
        i_pop  = ($urandom % 4) == 0;
      end else begin
        i_push = ($urandom % 4) == 0;
        i_pop  = ($urandom % 4) != 0;
      end
      i_data = fifo_data_t'($urandom);
      @(negedge i_clk);
    end
    i_push = 1'b0;
    i_pop  = 1'b0;
    drain(popped);
    check_value("model size after random drain", 32'(model_q.size()), 32'd0);

    // fill without popping so that extra pushes are dropped
    pulse_clear();
    push_words(TOTAL_WORDS + 4, 16'h1000);
    wait_for_flag("full", 1'b1, FLAG_LIMIT);
    check_value("completely_full", 32'(o_status.completely_full), 32'd1);
    push_words(3, 16'h1f00);
    check_value("completely_full", 32'(o_status.completely_full), 32'd1);
    check_value("words held when full", 32'(model_q.size()), 32'(TOTAL_WORDS));
    drain(popped);
    check_value("words drained", 32'(popped), 32'(TOTAL_WORDS));

    // one word below the almost-full level
    pulse_clear();
    push_words(THRESHOLD_WORDS - 1, 16'h2000);
    wait_for_flag("empty", 1'b0, FLAG_LIMIT);
    repeat (SETTLE_CYCLES) begin
      check_value("almost_full", 32'(o_status.almost_full), 32'd0);
      @(negedge i_clk);
    end
    // the last word pushes the SRAM part to the threshold
    push_words(1, 16'h20ff);
    wait_for_flag("almost_full", 1'b1, FLAG_LIMIT);
    check_value("full", 32'(o_status.full), 32'd0);
    drain(popped);
    check_value("words drained", 32'(popped), 32'(THRESHOLD_WORDS));

    // clear while half full
    push_words(TOTAL_WORDS / 2, 16'h3000);
    wait_for_flag("empty", 1'b0, FLAG_LIMIT);
    pulse_clear();
    check_value("empty after clear", 32'(o_status.empty), 32'd1);
    check_value("completely_empty after clear", 32'(o_status.completely_empty), 32'd1);
    push_words(5, 16'h5000);
    drain(popped);
    check_value("words drained after clear", 32'(popped), 32'd5);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/sram_fifo_pkg.sv
design/fifo_controller.sv
design/sram_array.sv
design/sram_read_buffer.sv
design/sram_fifo.sv
tb/sram_fifo_sva.sv
tb/sram_fifo_tb.sv
